/* Bender.yml */
package:
  name: digit_classifier

sources:
  - source/classifier_pkg.sv
  - source/classifier_ifs.sv
  - source/uart_rx.sv
  - source/uart_tx.sv
  - source/weight_loader.sv
  - source/image_loader.sv
  - source/param_mem.sv
  - source/fc_engine.sv
  - source/command_responder.sv
  - source/digit_classifier_top.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_digit_classifier.sv

/* source/classifier_ifs.sv */
`timescale 1ns/100ps

// Simple dual port memory access, one write port and one read port
interface mem_if #(
    parameter type data_t = classifier_pkg::byte_t,
    parameter int  ADDR_W = 8
);
    // Write side, one write per cycle with wr_en high
    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;
    data_t             wr_data;

    // Read side, rd_data follows rd_addr by one cycle
    logic [ADDR_W-1:0] rd_addr;
    data_t             rd_data;

    modport writer (output wr_en, output wr_addr, output wr_data);
    modport reader (output rd_addr, input rd_data);
    modport mem (input wr_en, input wr_addr, input wr_data, input rd_addr, output rd_data);
endinterface

// Engine results towards the command side
interface result_if;
    import classifier_pkg::*;

    logic   busy;
    logic   score_wr;
    digit_t score_class;
    score_t score;
    logic   done;
    digit_t digit;

    modport engine (output busy, output score_wr, output score_class,
                    output score, output done, output digit);
    modport store (input busy, input score_wr, input score_class,
                   input score, input done, input digit);
endinterface

/* source/classifier_pkg.sv */
package classifier_pkg;

    // ========================================
    // Data types
    // ========================================

    // One UART byte, also one image pixel
    typedef logic [7:0] byte_t;

    // Fully connected weight, two's complement
    typedef logic signed [7:0] weight_t;

    // Class score and class bias
    typedef logic signed [31:0] score_t;

    // Class index or predicted digit
    typedef logic [3:0] digit_t;

    // ========================================
    // Sizes and command codes
    // ========================================

    localparam int NUM_CLASSES = 10;

    // Bytes per score, in loading and in replies
    localparam int SCORE_BYTES = 4;

    localparam byte_t CMD_DIGIT     = 8'h44;
    localparam byte_t CMD_SCORES    = 8'h53;
    localparam byte_t CMD_NEW_IMAGE = 8'h4E;

endpackage

/* source/command_responder.sv */
`timescale 1ns/100ps

module command_responder (
    input  logic                  clk,
    input  logic                  rst,
    input  classifier_pkg::byte_t rx_byte,
    input  logic                  rx_valid,
    input  logic                  bytes_claimed,
    result_if.store               res,
    output logic                  rearm,
    output classifier_pkg::byte_t tx_byte,
    output logic                  tx_send,
    input  logic                  tx_busy
);
    import classifier_pkg::*;

    localparam int REPLY_MAX = NUM_CLASSES * SCORE_BYTES;
    localparam int IW        = $clog2(REPLY_MAX);

    // Latest results
    score_t scores [NUM_CLASSES];
    digit_t digit_q;

    // Command intake
    logic  cmd_valid;
    logic  known;
    logic  hold;
    logic  take_now;
    logic  take_pend;
    logic  serve;
    logic  pend_valid;
    byte_t pend_cmd;
    byte_t serve_cmd;

    // Reply sequencer
    logic          replying;
    logic          reply_scores;
    logic [IW-1:0] idx;
    logic          last_idx;
    logic          send_now;
    score_t        cur_score;

    assign cmd_valid = rx_valid && !bytes_claimed;
    assign known     = rx_byte == CMD_DIGIT || rx_byte == CMD_SCORES ||
                       rx_byte == CMD_NEW_IMAGE;
    // Held while inference runs, dropped during a reply
    assign hold      = cmd_valid && known && res.busy && !pend_valid && !replying;
    assign take_now  = cmd_valid && known && !res.busy && !pend_valid && !replying;
    assign take_pend = pend_valid && !res.busy && !replying;
    assign serve     = take_now || take_pend;
    assign serve_cmd = take_pend ? pend_cmd : rx_byte;

    assign last_idx  = !reply_scores || idx == IW'(REPLY_MAX - 1);
    // Skip the cycle where the transmitter has not yet raised busy
    assign send_now  = replying && !tx_busy && !tx_send;
    assign cur_score = scores[idx / SCORE_BYTES];

    always_ff @(posedge clk) begin
        if (res.score_wr) scores[res.score_class] <= res.score;
        if (res.done) digit_q <= res.digit;
        if (hold) pend_cmd <= rx_byte;
        if (send_now) begin
            tx_byte <= reply_scores ? byte_t'(cur_score >> (8 * (idx % SCORE_BYTES)))
                                    : byte_t'(digit_q);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pend_valid   <= 1'b0;
            replying     <= 1'b0;
            reply_scores <= 1'b0;
            idx          <= '0;
            rearm        <= 1'b0;
            tx_send      <= 1'b0;
        end else begin
            rearm   <= serve && serve_cmd == CMD_NEW_IMAGE;
            tx_send <= send_now;
            if (hold) begin
                pend_valid <= 1'b1;
            end else if (take_pend) begin
                pend_valid <= 1'b0;
            end
            if (serve && serve_cmd != CMD_NEW_IMAGE) begin
                replying     <= 1'b1;
                reply_scores <= serve_cmd == CMD_SCORES;
                idx          <= '0;
            end else if (send_now) begin
                if (last_idx) begin
                    replying <= 1'b0;
                end else begin
                    idx <= idx + 1'b1;
                end
            end
        end
    end

endmodule

/* source/digit_classifier_top.sv */
`timescale 1ns/100ps

module digit_classifier_top #(
    parameter int IMG_PIXELS   = 784,
    parameter int CLKS_PER_BIT = 868
) (
    input  logic clk,
    input  logic rst,
    input  logic rx,
    output logic tx
);
    import classifier_pkg::*;

    localparam int W_DEPTH = NUM_CLASSES * IMG_PIXELS;

    byte_t rx_byte;
    byte_t tx_byte;
    logic  rx_valid;
    logic  weights_loaded;
    logic  bytes_claimed;
    logic  image_done;
    logic  rearm;
    logic  tx_send;
    logic  tx_busy;

    mem_if #(.data_t(weight_t), .ADDR_W($clog2(W_DEPTH))) weight_bus ();
    mem_if #(.data_t(score_t), .ADDR_W($bits(digit_t))) bias_bus ();
    mem_if #(.data_t(byte_t), .ADDR_W($clog2(IMG_PIXELS))) image_bus ();
    result_if result_bus ();

    // ========================================
    // Serial input and loaders
    // ========================================

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_rx_i (
        .clk      (clk),
        .rst      (rst),
        .rx       (rx),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

    weight_loader #(.IMG_PIXELS(IMG_PIXELS)) weight_loader_i (
        .clk            (clk),
        .rst            (rst),
        .rx_byte        (rx_byte),
        .rx_valid       (rx_valid),
        .weights        (weight_bus.writer),
        .biases         (bias_bus.writer),
        .weights_loaded (weights_loaded)
    );

    image_loader #(.IMG_PIXELS(IMG_PIXELS)) image_loader_i (
        .clk            (clk),
        .rst            (rst),
        .rx_byte        (rx_byte),
        .rx_valid       (rx_valid),
        .weights_loaded (weights_loaded),
        .rearm          (rearm),
        .image          (image_bus.writer),
        .bytes_claimed  (bytes_claimed),
        .image_done     (image_done)
    );

    // Parameter and image storage
    param_mem #(.data_t(weight_t), .DEPTH(W_DEPTH)) weight_mem_i (
        .clk  (clk),
        .port (weight_bus.mem)
    );

    param_mem #(.data_t(score_t), .DEPTH(NUM_CLASSES)) bias_mem_i (
        .clk  (clk),
        .port (bias_bus.mem)
    );

    param_mem #(.data_t(byte_t), .DEPTH(IMG_PIXELS)) image_mem_i (
        .clk  (clk),
        .port (image_bus.mem)
    );

    // ========================================
    // Inference and replies
    // ========================================

    fc_engine #(.IMG_PIXELS(IMG_PIXELS)) fc_engine_i (
        .clk     (clk),
        .rst     (rst),
        .start   (image_done),
        .image   (image_bus.reader),
        .weights (weight_bus.reader),
        .biases  (bias_bus.reader),
        .res     (result_bus.engine)
    );

    command_responder command_responder_i (
        .clk           (clk),
        .rst           (rst),
        .rx_byte       (rx_byte),
        .rx_valid      (rx_valid),
        .bytes_claimed (bytes_claimed),
        .res           (result_bus.store),
        .rearm         (rearm),
        .tx_byte       (tx_byte),
        .tx_send       (tx_send),
        .tx_busy       (tx_busy)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_tx_i (
        .clk     (clk),
        .rst     (rst),
        .tx_byte (tx_byte),
        .tx_send (tx_send),
        .tx      (tx),
        .tx_busy (tx_busy)
    );

endmodule

/* source/fc_engine.sv */
`timescale 1ns/100ps

module fc_engine #(
    parameter int IMG_PIXELS = 784
) (
    input logic      clk,
    input logic      rst,
    input logic      start,
    mem_if.reader    image,
    mem_if.reader    weights,
    mem_if.reader    biases,
    result_if.engine res
);
    import classifier_pkg::*;

    localparam int     W_AW     = $clog2(NUM_CLASSES * IMG_PIXELS);
    localparam int     P_AW     = $clog2(IMG_PIXELS);
    localparam digit_t LAST_CLS = digit_t'(NUM_CLASSES - 1);

    // ========================================
    // Address issue stage
    // ========================================

    logic            issuing;
    logic            last_pix;
    logic [P_AW-1:0] pix;
    logic [W_AW-1:0] w_addr;
    digit_t          cls;

    // Data stage, read data valid
    logic   v1;
    logic   first1;
    logic   last1;
    digit_t cls1;

    // Accumulate stage
    logic               v2;
    logic               first2;
    logic               last2;
    digit_t             cls2;
    logic signed [16:0] prod;
    score_t             bias_q;
    score_t             acc;
    score_t             sum;
    score_t             max_score;
    digit_t             max_idx;
    logic               final_wr;

    assign last_pix = pix == P_AW'(IMG_PIXELS - 1);

    // Weights are class-major, so one linear address walks them all
    assign image.rd_addr   = pix;
    assign weights.rd_addr = w_addr;
    assign biases.rd_addr  = cls;

    // First product of a class starts from its bias
    assign sum       = (first2 ? bias_q : acc) + prod;
    assign final_wr  = res.score_wr && res.score_class == LAST_CLS;
    assign res.digit = max_idx;

    always_ff @(posedge clk) begin
        if (rst) begin
            issuing      <= 1'b0;
            pix          <= '0;
            w_addr       <= '0;
            cls          <= '0;
            v1           <= 1'b0;
            v2           <= 1'b0;
            res.busy     <= 1'b0;
            res.score_wr <= 1'b0;
            res.done     <= 1'b0;
        end else begin
            v1           <= issuing;
            v2           <= v1;
            res.score_wr <= v2 && last2;
            res.done     <= final_wr;
            if (final_wr) res.busy <= 1'b0;
            if (start) begin
                issuing  <= 1'b1;
                res.busy <= 1'b1;
                pix      <= '0;
                w_addr   <= '0;
                cls      <= '0;
            end else if (issuing) begin
                if (last_pix && cls == LAST_CLS) begin
                    issuing <= 1'b0;
                end else begin
                    w_addr <= w_addr + 1'b1;
                    pix    <= last_pix ? '0 : pix + 1'b1;
                    if (last_pix) cls <= cls + 1'b1;
                end
            end
        end
    end

    // ========================================
    // MAC pipeline and argmax
    // ========================================

    always_ff @(posedge clk) begin
        first1 <= pix == '0;
        last1  <= last_pix;
        cls1   <= cls;
        first2 <= first1;
        last2  <= last1;
        cls2   <= cls1;
        // Pixel is unsigned, widen before the signed multiply
        prod <= $signed({1'b0, image.rd_data}) * weights.rd_data;
        if (first1) bias_q <= biases.rd_data;
        if (v2) acc <= sum;
        res.score       <= sum;
        res.score_class <= cls2;
        // Strictly greater keeps the lowest index on a tie
        if (v2 && last2 && (cls2 == '0 || sum > max_score)) begin
            max_score <= sum;
            max_idx   <= cls2;
        end
    end

    assert property (@(posedge clk) disable iff (rst) res.done |-> $past(res.busy));

endmodule

/* source/image_loader.sv */
`timescale 1ns/100ps

module image_loader #(
    parameter int IMG_PIXELS = 784
) (
    input  logic                  clk,
    input  logic                  rst,
    input  classifier_pkg::byte_t rx_byte,
    input  logic                  rx_valid,
    input  logic                  weights_loaded,
    input  logic                  rearm,
    mem_if.writer                 image,
    output logic                  bytes_claimed,
    output logic                  image_done
);
    localparam int AW = $clog2(IMG_PIXELS);

    logic          armed;
    logic          take;
    logic          last_pix;
    logic          last_wr;
    logic [AW-1:0] pix_addr;

    assign take     = rx_valid && weights_loaded && armed;
    assign last_pix = pix_addr == AW'(IMG_PIXELS - 1);
    // Weight bytes and pixel bytes never reach the command side
    assign bytes_claimed = !weights_loaded || armed;

    always_ff @(posedge clk) begin
        if (rst) begin
            armed       <= 1'b1;
            pix_addr    <= '0;
            last_wr     <= 1'b0;
            image_done  <= 1'b0;
            image.wr_en <= 1'b0;
        end else begin
            image.wr_en <= take;
            last_wr     <= take && last_pix;
            image_done  <= last_wr;
            if (take) begin
                pix_addr <= last_pix ? '0 : pix_addr + 1'b1;
                // Disarm until the next new image command
                if (last_pix) armed <= 1'b0;
            end else if (rearm) begin
                armed <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            image.wr_addr <= pix_addr;
            image.wr_data <= rx_byte;
        end
    end

endmodule

/* source/param_mem.sv */
`timescale 1ns/100ps

module param_mem #(
    parameter type data_t = classifier_pkg::byte_t,
    parameter int  DEPTH  = 16
) (
    input logic clk,
    mem_if.mem  port
);
    data_t ram [DEPTH];

    // Registered read, one cycle latency
    always_ff @(posedge clk) begin
        if (port.wr_en) ram[port.wr_addr] <= port.wr_data;
        port.rd_data <= ram[port.rd_addr];
    end

    // Loaders stay inside the array
    assert property (@(posedge clk) port.wr_en |-> port.wr_addr < DEPTH);

endmodule

/* source/uart_rx.sv */
`timescale 1ns/100ps

module uart_rx #(
    parameter int CLKS_PER_BIT = 868
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rx,
    output classifier_pkg::byte_t rx_byte,
    output logic                  rx_valid
);
    localparam int CW = $clog2(CLKS_PER_BIT);

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} state_t;

    state_t        state;
    logic          rx_meta;
    logic          rx_sync;
    logic [CW-1:0] clk_cnt;
    logic [2:0]    bit_idx;
    logic          bit_end;

    // Full bit period elapsed, counted from mid start bit
    assign bit_end = clk_cnt == CW'(CLKS_PER_BIT - 1);

    // Two-flop synchronizer, line idles high
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                IDLE: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    if (!rx_sync) state <= START;
                end
                START: begin
                    // Start bit must still be low at mid-bit
                    if (clk_cnt == CW'(CLKS_PER_BIT / 2 - 1)) begin
                        clk_cnt <= '0;
                        state   <= rx_sync ? IDLE : DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                DATA: begin
                    clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= STOP;
                    end
                end
                default: begin
                    // Mid stop bit, framing error drops the byte
                    clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
                    if (bit_end) begin
                        rx_valid <= rx_sync;
                        state    <= IDLE;
                    end
                end
            endcase
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge clk) begin
        if (state == DATA && bit_end) rx_byte <= {rx_sync, rx_byte[7:1]};
    end

    // At most one strobe per frame
    assert property (@(posedge clk) disable iff (rst) rx_valid |=> !rx_valid);

endmodule

/* source/uart_tx.sv */
`timescale 1ns/100ps

module uart_tx #(
    parameter int CLKS_PER_BIT = 868
) (
    input  logic                  clk,
    input  logic                  rst,
    input  classifier_pkg::byte_t tx_byte,
    input  logic                  tx_send,
    output logic                  tx,
    output logic                  tx_busy
);
    localparam int CW = $clog2(CLKS_PER_BIT);

    // Remaining data bits plus stop bit
    logic [8:0]    shreg;
    logic [3:0]    bit_cnt;
    logic [CW-1:0] baud_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            tx       <= 1'b1;
            tx_busy  <= 1'b0;
            bit_cnt  <= '0;
            baud_cnt <= '0;
        end else if (!tx_busy) begin
            if (tx_send) begin
                // Start bit goes out at once
                tx       <= 1'b0;
                tx_busy  <= 1'b1;
                bit_cnt  <= '0;
                baud_cnt <= '0;
            end
        end else if (baud_cnt == CW'(CLKS_PER_BIT - 1)) begin
            baud_cnt <= '0;
            if (bit_cnt == 4'd9) begin
                tx_busy <= 1'b0;
            end else begin
                tx      <= shreg[0];
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!tx_busy && tx_send) begin
            shreg <= {1'b1, tx_byte};
        end else if (tx_busy && baud_cnt == CW'(CLKS_PER_BIT - 1)) begin
            shreg <= {1'b1, shreg[8:1]};
        end
    end

    // Sender waits for the line to be free
    assert property (@(posedge clk) disable iff (rst) tx_send |-> !tx_busy);

endmodule

/* source/weight_loader.sv */
`timescale 1ns/100ps

module weight_loader #(
    parameter int IMG_PIXELS = 784
) (
    input  logic                  clk,
    input  logic                  rst,
    input  classifier_pkg::byte_t rx_byte,
    input  logic                  rx_valid,
    mem_if.writer                 weights,
    mem_if.writer                 biases,
    output logic                  weights_loaded
);
    import classifier_pkg::*;

    localparam int W_DEPTH = NUM_CLASSES * IMG_PIXELS;
    localparam int W_AW    = $clog2(W_DEPTH);
    localparam int BW      = $clog2(SCORE_BYTES);

    logic            take;
    logic            in_bias;
    logic [W_AW-1:0] w_addr;
    logic [BW-1:0]   b_byte;
    logic            last_byte;
    digit_t          b_idx;
    score_t          bias_acc;
    score_t          bias_next;

    assign take      = rx_valid && !weights_loaded;
    assign last_byte = b_byte == BW'(SCORE_BYTES - 1);
    // Little endian, newest byte enters at the top
    assign bias_next = {rx_byte, bias_acc[$bits(score_t)-1:8]};

    always_ff @(posedge clk) begin
        if (rst) begin
            in_bias        <= 1'b0;
            w_addr         <= '0;
            b_byte         <= '0;
            b_idx          <= '0;
            weights_loaded <= 1'b0;
            weights.wr_en  <= 1'b0;
            biases.wr_en   <= 1'b0;
        end else begin
            weights.wr_en <= take && !in_bias;
            biases.wr_en  <= take && in_bias && last_byte;
            // Weight phase, class-major order
            if (take && !in_bias) begin
                w_addr <= w_addr + 1'b1;
                if (w_addr == W_AW'(W_DEPTH - 1)) in_bias <= 1'b1;
            end
            // Bias phase
            if (take && in_bias) begin
                b_byte <= last_byte ? '0 : b_byte + 1'b1;
                if (last_byte) begin
                    b_idx <= b_idx + 1'b1;
                    if (b_idx == digit_t'(NUM_CLASSES - 1)) weights_loaded <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            weights.wr_addr <= w_addr;
            weights.wr_data <= weight_t'(rx_byte);
            biases.wr_addr  <= b_idx;
            biases.wr_data  <= bias_next;
            bias_acc        <= bias_next;
        end
    end

endmodule

/* sources.f */
source/classifier_pkg.sv
source/classifier_ifs.sv
source/uart_rx.sv
source/uart_tx.sv
source/weight_loader.sv
source/image_loader.sv
source/param_mem.sv
source/fc_engine.sv
source/command_responder.sv
source/digit_classifier_top.sv
verification/tb_clock_gen.sv
verification/tb_digit_classifier.sv

/* verification/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // Reset held for a fixed count of rising edges, released just after one
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

/* verification/tb_digit_classifier.sv */
`timescale 1ns/100ps

module tb_digit_classifier;
    import classifier_pkg::*;

    localparam int IMG_PIXELS   = 16;
    localparam int CLKS_PER_BIT = 16;
    localparam int W_COUNT      = NUM_CLASSES * IMG_PIXELS;
    localparam int REPLY_BYTES  = NUM_CLASSES * SCORE_BYTES;
    localparam int DRIVE_DELAY  = 1;

    // Cycle budgets for the reply waits
    localparam int RESET_WAIT_CYCLES = 100;
    localparam int DIGIT_WAIT_CYCLES = 3000;
    localparam int SCORE_WAIT_CYCLES = 10000;
    localparam int QUIET_CYCLES      = 800;

    logic clk;
    logic rst;
    logic rx;
    logic tx;

    integer seed;
    int     error_count;
    int     tests_run;
    int     tests_failed;
    int     test_start_errors;
    int     tx_low_cycles;
    logic   quiet_watch;

    // Host side copy of everything loaded into the DUT
    weight_t weights [W_COUNT];
    score_t  biases [NUM_CLASSES];
    byte_t   pixels [IMG_PIXELS];
    score_t  model_scores [NUM_CLASSES];

    // Bytes decoded from the DUT's tx line, oldest first
    byte_t tx_bytes [$];

    tb_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(5)) clock_gen_i (
        .clk (clk),
        .rst (rst)
    );

    digit_classifier_top #(
        .IMG_PIXELS   (IMG_PIXELS),
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) digit_classifier_top_i (
        .clk (clk),
        .rst (rst),
        .rx  (rx),
        .tx  (tx)
    );

    // ========================================
    // Serial monitor and line watch
    // ========================================

    // Sampled on the falling edge, away from the DUT's register updates
    initial begin : tx_monitor
        byte_t value;
        int    bit_i;
        forever begin
            @(negedge clk);
            if (!rst && tx === 1'b0) begin
                // Move to the middle of the start bit
                repeat (CLKS_PER_BIT / 2) @(negedge clk);
                if (tx !== 1'b0) begin
                    $display("tx start bit went high again before mid-bit");
                    error_count++;
                end else begin
                    for (bit_i = 0; bit_i < 8; bit_i++) begin
                        repeat (CLKS_PER_BIT) @(negedge clk);
                        value[bit_i] = tx;
                    end
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    if (tx !== 1'b1) begin
                        $display("tx stop bit was low, byte dropped");
                        error_count++;
                    end else begin
                        tx_bytes.push_back(value);
                    end
                end
            end
        end
    end

    // Any cycle with tx not idle while the line should be quiet
    always @(negedge clk) begin
        if (quiet_watch && tx !== 1'b1) tx_low_cycles++;
    end

    // ========================================
    // Driver, model and check helpers
    // ========================================

    // 8N1 frame, LSB first, each bit changed just after a rising edge
    task automatic send_byte(input byte_t value);
        logic [9:0] frame;
        int         bit_i;
        frame = {1'b1, value, 1'b0};
        for (bit_i = 0; bit_i < 10; bit_i++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            rx = frame[bit_i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    task automatic send_image();
        int p;
        for (p = 0; p < IMG_PIXELS; p++) send_byte(pixels[p]);
    endtask

    task automatic wait_bytes(input int count, input int max_cycles, output logic arrived);
        int waited;
        waited = 0;
        while (tx_bytes.size() < count && waited < max_cycles) begin
            @(negedge clk);
            waited++;
        end
        arrived = tx_bytes.size() >= count;
    endtask

    // Bias plus unsigned pixel times signed weight, wrapping at 32 bits
    function automatic void compute_model();
        int c;
        int p;
        int acc;
        for (c = 0; c < NUM_CLASSES; c++) begin
            acc = biases[c];
            for (p = 0; p < IMG_PIXELS; p++) begin
                acc = acc + int'(pixels[p]) * int'(weights[c * IMG_PIXELS + p]);
            end
            model_scores[c] = acc;
        end
    endfunction

    // Highest score, lowest index on a tie
    function automatic int model_digit();
        int c;
        int best;
        best = 0;
        for (c = 1; c < NUM_CLASSES; c++) begin
            if (model_scores[c] > model_scores[best]) best = c;
        end
        return best;
    endfunction

    task automatic report_mismatch(input string test_name, input int expected, input int actual);
        $display("CHECK FAILED %s: expected %0d, actual %0d", test_name, expected, actual);
        error_count++;
    endtask

    // Reply too long if another byte shows up within the quiet window
    task automatic drop_extra_bytes(input string test_name);
        logic arrived;
        wait_bytes(1, QUIET_CYCLES, arrived);
        if (arrived) begin
            $display("%s: %0d reply bytes more than expected", test_name, tx_bytes.size());
            error_count++;
            tx_bytes.delete();
        end
    endtask

    task automatic check_digit(input string test_name, input int expected);
        logic  arrived;
        byte_t got;
        send_byte(CMD_DIGIT);
        wait_bytes(1, DIGIT_WAIT_CYCLES, arrived);
        if (!arrived) begin
            $display("%s: no digit reply before the timeout", test_name);
            error_count++;
        end else begin
            got = tx_bytes.pop_front();
            if (int'(got) != expected) report_mismatch(test_name, expected, int'(got));
            drop_extra_bytes(test_name);
        end
    endtask

    // Expected words are the biases or the model scores
    task automatic check_scores(input string test_name, input logic expect_biases);
        logic   arrived;
        score_t got;
        score_t expected;
        int     c;
        int     k;
        send_byte(CMD_SCORES);
        wait_bytes(REPLY_BYTES, SCORE_WAIT_CYCLES, arrived);
        if (!arrived) begin
            $display("%s: only %0d of %0d score bytes before the timeout",
                     test_name, tx_bytes.size(), REPLY_BYTES);
            error_count++;
            tx_bytes.delete();
        end else begin
            for (c = 0; c < NUM_CLASSES; c++) begin
                // Little endian, class 0 first
                for (k = 0; k < SCORE_BYTES; k++) got[8 * k +: 8] = tx_bytes.pop_front();
                expected = expect_biases ? biases[c] : model_scores[c];
                if (got != expected) report_mismatch(test_name, expected, got);
            end
            drop_extra_bytes(test_name);
        end
    endtask

    task automatic finish_test(input string test_name);
        tests_run++;
        if (error_count == test_start_errors) begin
            $display("test %s passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s failed, %0d errors", test_name, error_count - test_start_errors);
        end
        test_start_errors = error_count;
    endtask

    // ========================================
    // Test sequence
    // ========================================

    initial begin : main
        logic  arrived;
        byte_t unknown;
        int    i;
        int    k;
        int    waited;

        rx                = 1'b1;
        seed              = 32'h6b43_5931;
        error_count       = 0;
        tests_run         = 0;
        tests_failed      = 0;
        test_start_errors = 0;
        tx_low_cycles     = 0;
        quiet_watch       = 1'b0;

        // Random parameters and first image
        for (i = 0; i < W_COUNT; i++) weights[i] = weight_t'($random(seed));
        for (i = 0; i < NUM_CLASSES; i++) biases[i] = score_t'($random(seed) % 50000);
        // Last class ties with the largest earlier bias
        biases[NUM_CLASSES - 1] = biases[0];
        for (i = 1; i < NUM_CLASSES - 1; i++) begin
            if (biases[i] > biases[NUM_CLASSES - 1]) biases[NUM_CLASSES - 1] = biases[i];
        end
        for (i = 0; i < IMG_PIXELS; i++) pixels[i] = byte_t'($random(seed));
        compute_model();

        waited = 0;
        while (rst !== 1'b0 && waited < RESET_WAIT_CYCLES) begin
            @(posedge clk);
            waited++;
        end
        if (rst !== 1'b0) begin
            $display("reset was never released");
            error_count++;
        end
        quiet_watch = 1'b1;

        // Weights class-major, then biases little endian, then the image
        for (i = 0; i < W_COUNT; i++) send_byte(weights[i]);
        for (i = 0; i < NUM_CLASSES; i++) begin
            for (k = 0; k < SCORE_BYTES; k++) send_byte(biases[i][8 * k +: 8]);
        end
        send_image();
        quiet_watch = 1'b0;
        if (tx_low_cycles != 0) report_mismatch("quiet_load", 0, tx_low_cycles);
        if (tx_bytes.size() != 0) report_mismatch("quiet_load", 0, tx_bytes.size());
        tx_bytes.delete();
        finish_test("quiet_load");

        // Sent at once, inference may still be running
        check_digit("digit_after_load", model_digit());
        finish_test("digit_after_load");

        check_scores("scores_after_load", 1'b0);
        finish_test("scores_after_load");

        // All-zero image leaves only the biases
        send_byte(CMD_NEW_IMAGE);
        for (i = 0; i < IMG_PIXELS; i++) pixels[i] = 8'h00;
        send_image();
        compute_model();
        check_scores("zero_image", 1'b1);
        check_digit("zero_image", model_digit());
        finish_test("zero_image");

        send_byte(CMD_NEW_IMAGE);
        for (i = 0; i < IMG_PIXELS; i++) pixels[i] = byte_t'($random(seed));
        send_image();
        compute_model();
        check_digit("second_image", model_digit());
        check_scores("second_image", 1'b0);
        finish_test("second_image");

        // Any byte outside the command set
        do begin
            unknown = byte_t'($random(seed));
        end while (unknown == CMD_DIGIT || unknown == CMD_SCORES || unknown == CMD_NEW_IMAGE);
        send_byte(unknown);
        wait_bytes(1, QUIET_CYCLES, arrived);
        if (arrived) begin
            report_mismatch("unknown_command", 0, tx_bytes.size());
            tx_bytes.delete();
        end
        check_digit("unknown_command", model_digit());
        finish_test("unknown_command");

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
